/* bench/tlb_checker.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_checker (
  input logic                 clk,
  input logic                 rst,
  input logic                 resp_valid,
  input tlb_pkg::port_e       resp_port,
  input logic [`TLB_PA_W-1:0] resp_paddr,
  input logic [7:0]           resp_exc,
  input logic                 resp_credit,
  input logic                 inst_credit,
  input logic                 data_credit
);

  logic [`TLB_PA_W+7:0] inst_q [$];  // {paddr, exc} in request order
  logic [`TLB_PA_W+7:0] data_q [$];
  int   n_resp = 0;
  int   n_err = 0;
  int   in_flight = 0;  // sent but not yet credited back
  logic credit_prev = 1'b0;

  task automatic push_expect(input tlb_pkg::port_e port, input logic [`TLB_PA_W-1:0] paddr,
                             input logic [7:0] exc);
    if (port == tlb_pkg::port_inst) inst_q.push_back({paddr, exc});
    else data_q.push_back({paddr, exc});
  endtask

  function automatic int pending(input tlb_pkg::port_e port);
    return (port == tlb_pkg::port_inst) ? inst_q.size() : data_q.size();
  endfunction

  task automatic report_counts();
    $display("%0d responses checked, %0d errors", n_resp, n_err);
  endtask

  always @(posedge clk) begin
    logic [`TLB_PA_W+7:0] want;
    logic                 found;
    int                   errs_before;
    string                pname;
    logic                 exp_ic;
    logic                 exp_dc;
    if (rst) begin
      in_flight = 0;
      credit_prev = 1'b0;
    end else begin
      if (resp_valid) begin
        n_resp++;
        errs_before = n_err;
        pname = (resp_port == tlb_pkg::port_inst) ? "inst" : "data";
        // credit seen on the previous edge was already usable by this send
        if (in_flight >= `TLB_RESP_CREDITS) begin
          $display("%s port response sent while no response credit was left", pname);
          n_err++;
        end
        found = 1'b1;
        want = '0;
        if (resp_port == tlb_pkg::port_inst && inst_q.size() != 0) want = inst_q.pop_front();
        else if (resp_port == tlb_pkg::port_data && data_q.size() != 0) want = data_q.pop_front();
        else found = 1'b0;
        if (!found) begin
          $display("%s port sent a response that no request asked for", pname);
          n_err++;
        end else begin
          if (resp_paddr !== want[`TLB_PA_W+7:8]) begin
            $display("ERROR %s resp_paddr: got 0x%05h, expected 0x%05h",
                     pname, resp_paddr, want[`TLB_PA_W+7:8]);
            n_err++;
          end
          if (resp_exc !== want[7:0]) begin
            $display("ERROR %s resp_exc: got 0x%02h, expected 0x%02h", pname, resp_exc, want[7:0]);
            n_err++;
          end
        end
        $display("response %0d on %s: paddr %05h exc %02h %s", n_resp, pname, resp_paddr,
                 resp_exc, (n_err == errs_before) ? "ok" : "mismatch");
      end
      // a request credit goes back on the edge that sends that port's response
      exp_ic = resp_valid && (resp_port == tlb_pkg::port_inst);
      exp_dc = resp_valid && (resp_port == tlb_pkg::port_data);
      if (inst_credit !== exp_ic) begin
        $display("ERROR inst_credit: got 0x%0h, expected 0x%0h", inst_credit, exp_ic);
        n_err++;
      end
      if (data_credit !== exp_dc) begin
        $display("ERROR data_credit: got 0x%0h, expected 0x%0h", data_credit, exp_dc);
        n_err++;
      end
      in_flight = in_flight + int'(resp_valid) - int'(credit_prev);
      credit_prev = resp_credit;
    end
  end

endmodule

/* bench/tlb_tb.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_tb;

  localparam logic [2:0] op_fill  = 3'd0;
  localparam logic [2:0] op_clear = 3'd1;
  localparam logic [2:0] op_inst  = 3'd2;
  localparam logic [2:0] op_data  = 3'd3;
  localparam logic [2:0] op_both  = 3'd4;
  localparam logic [2:0] op_hold  = 3'd5;  // withhold response credits for a while

  typedef struct packed {
    logic [2:0]           op;
    logic [31:0]          vaddr;
    logic [`TLB_PID_W-1:0] pid;
    logic                 kmode;
    logic [7:0]           exc;
    logic [`TLB_PPN_W-1:0] ppn;
    logic [`TLB_PA_W-1:0] exp_paddr;
    logic [7:0]           exp_exc;
  } row_t;

  row_t rows [$];

  logic                  clk = 1'b0;
  logic                  rst = 1'b1;
  logic                  inst_valid = 1'b0;
  logic [31:0]           inst_vaddr = '0;
  logic [`TLB_PID_W-1:0] inst_pid = '0;
  logic                  inst_kmode = 1'b0;
  logic                  data_valid = 1'b0;
  logic [31:0]           data_vaddr = '0;
  logic [`TLB_PID_W-1:0] data_pid = '0;
  logic                  data_kmode = 1'b0;
  logic [7:0]            data_exc_in = '0;
  logic                  fill_valid = 1'b0;
  logic [`TLB_PID_W-1:0] fill_pid = '0;
  logic [`TLB_VPN_W-1:0] fill_vpn = '0;
  logic [`TLB_PPN_W-1:0] fill_ppn = '0;
  logic                  clear = 1'b0;
  logic                  resp_credit = 1'b0;
  logic                  inst_credit;
  logic                  data_credit;
  logic                  resp_valid;
  tlb_pkg::port_e        resp_port;
  logic [`TLB_PA_W-1:0]  resp_paddr;
  logic [7:0]            resp_exc;

  logic hold_pulse = 1'b0;
  int   hold_left = 0;
  int   inst_cnt = 0;  // request credits held by the sender
  int   data_cnt = 0;
  int   cycles = 0;
  int   limit = 0;
  int   due [$];       // cycles at which response credits go back

  tlb_top dut0 (.*);
  tlb_checker chk (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic add_row(input logic [2:0] op, input logic [31:0] vaddr,
                         input logic [`TLB_PID_W-1:0] pid, input logic kmode,
                         input logic [7:0] exc, input logic [`TLB_PPN_W-1:0] ppn,
                         input logic [`TLB_PA_W-1:0] exp_paddr, input logic [7:0] exp_exc);
    rows.push_back({op, vaddr, pid, kmode, exc, ppn, exp_paddr, exp_exc});
  endtask

  task automatic build_table();
    add_row(op_inst, 32'h0001_0abc, 12'h000, 1'b1, 8'h00, 6'h00, 18'h10abc, 8'h00);
    add_row(op_fill, 32'h1234_5000, 12'h005, 1'b0, 8'h00, 6'h0a, 18'h00000, 8'h00);
    add_row(op_fill, 32'h0004_0000, 12'h005, 1'b0, 8'h00, 6'h11, 18'h00000, 8'h00);
    add_row(op_inst, 32'h1234_5678, 12'h005, 1'b0, 8'h00, 6'h00, 18'h0a678, 8'h00);
    add_row(op_data, 32'h0004_0abc, 12'h005, 1'b0, 8'h00, 6'h00, 18'h11abc, 8'h00);
    add_row(op_both, 32'h1234_5010, 12'h005, 1'b0, 8'h00, 6'h00, 18'h0a010, 8'h00);
    add_row(op_inst, 32'h1234_5678, 12'h006, 1'b0, 8'h00, 6'h00, 18'h00000, 8'h82);
    add_row(op_data, 32'h0002_1234, 12'h000, 1'b1, 8'h00, 6'h00, 18'h21234, 8'h00);
    add_row(op_inst, 32'h0003_0000, 12'h000, 1'b1, 8'h00, 6'h00, 18'h00000, 8'h83);
    add_row(op_data, 32'h1234_5678, 12'h005, 1'b0, 8'h45, 6'h00, 18'h00000, 8'h45);
    for (int k = 1; k <= 6; k++) begin  // slots 2 to 7
      add_row(op_fill, {20'h20000 + 20'(k), 12'h000}, 12'h007, 1'b0, 8'h00, 6'h20 + 6'(k),
              18'h00000, 8'h00);
    end
    add_row(op_fill, 32'h3000_0000, 12'h005, 1'b0, 8'h00, 6'h3f, 18'h00000, 8'h00);  // slot 0
    add_row(op_inst, 32'h1234_5678, 12'h005, 1'b0, 8'h00, 6'h00, 18'h00000, 8'h82);
    add_row(op_data, 32'h3000_0001, 12'h005, 1'b0, 8'h00, 6'h00, 18'h3f001, 8'h00);
    add_row(op_both, 32'h2000_3fff, 12'h007, 1'b0, 8'h00, 6'h00, 18'h23fff, 8'h00);
    add_row(op_clear, 32'h0, 12'h000, 1'b0, 8'h00, 6'h00, 18'h00000, 8'h00);
    add_row(op_inst, 32'h0004_0abc, 12'h005, 1'b0, 8'h00, 6'h00, 18'h00000, 8'h82);
    add_row(op_data, 32'h3000_0001, 12'h005, 1'b1, 8'h00, 6'h00, 18'h00000, 8'h83);
    add_row(op_hold, 32'h0, 12'h000, 1'b0, 8'h00, 6'h00, 18'h00000, 8'h00);
    for (int k = 1; k <= 5; k++) begin
      add_row(op_both, 32'h0002_0000 + 32'(k * 256), 12'h000, 1'b1, 8'h00, 6'h00,
              18'h20000 + 18'(k * 256), 8'h00);
    end
  endtask

  initial begin
    int   i;
    row_t r;
    logic need_i;
    logic need_d;
    void'($urandom(32'h54b93077));
    build_table();
    limit = rows.size() * 20 + 100;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    i = 0;
    while (i < rows.size()) begin
      @(posedge clk);
      r = rows[i];
      inst_valid <= 1'b0;
      data_valid <= 1'b0;
      fill_valid <= 1'b0;
      clear      <= 1'b0;
      hold_pulse <= 1'b0;
      need_i = (r.op == op_inst) || (r.op == op_both);
      need_d = (r.op == op_data) || (r.op == op_both);
      // a request driven last cycle is consumed at this edge
      if ((!need_i || inst_cnt - int'(inst_valid) > 0) &&
          (!need_d || data_cnt - int'(data_valid) > 0)) begin
        case (r.op)
          op_fill: begin
            fill_valid <= 1'b1;
            fill_pid   <= r.pid;
            fill_vpn   <= r.vaddr[31:`TLB_OFF_W];
            fill_ppn   <= r.ppn;
          end
          op_clear: clear <= 1'b1;
          op_hold:  hold_pulse <= 1'b1;
          default: begin
            if (need_i) begin
              inst_valid <= 1'b1;
              inst_vaddr <= r.vaddr;
              inst_pid   <= r.pid;
              inst_kmode <= r.kmode;
              chk.push_expect(tlb_pkg::port_inst, r.exp_paddr, r.exp_exc);
            end
            if (need_d) begin
              data_valid  <= 1'b1;
              data_vaddr  <= r.vaddr;
              data_pid    <= r.pid;
              data_kmode  <= r.kmode;
              data_exc_in <= r.exc;
              chk.push_expect(tlb_pkg::port_data, r.exp_paddr, r.exp_exc);
            end
          end
        endcase
        i++;
      end
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    data_valid <= 1'b0;
    fill_valid <= 1'b0;
    clear      <= 1'b0;
    hold_pulse <= 1'b0;
    @(negedge clk);
    while (chk.pending(tlb_pkg::port_inst) + chk.pending(tlb_pkg::port_data) != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);  // catch stray responses
    chk.report_counts();
    if (chk.n_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    if (rst) begin
      inst_cnt <= `TLB_REQ_CREDITS;
      data_cnt <= `TLB_REQ_CREDITS;
    end else begin
      inst_cnt <= inst_cnt + int'(inst_credit) - int'(inst_valid);
      data_cnt <= data_cnt + int'(data_credit) - int'(data_valid);
    end
  end

  // downstream returns each credit after 0 to 3 cycles
  always @(posedge clk) begin
    if (rst) begin
      resp_credit <= 1'b0;
      hold_left   <= 0;
    end else begin
      if (resp_valid) due.push_back(cycles + int'($urandom % 4));
      if (hold_pulse) hold_left <= 30;
      else if (hold_left != 0) hold_left <= hold_left - 1;
      if (hold_left == 0 && due.size() != 0 && due[0] <= cycles) begin
        resp_credit <= 1'b1;
        void'(due.pop_front());
      end else begin
        resp_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles: inst port waits for %0d, data port for %0d responses",
               cycles, chk.pending(tlb_pkg::port_inst), chk.pending(tlb_pkg::port_data));
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_entry_store.sv
verilog/tlb_lookup.sv
verilog/tlb_resp_merge.sv
verilog/tlb_top.sv
bench/tlb_checker.sv
bench/tlb_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tlb_tb -f flist.f -o tlb_sim
./obj_dir/tlb_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* verilog/tlb_entry_store.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_entry_store (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               fill_valid,
  input  logic [`TLB_PID_W-1:0]                              fill_pid,
  input  logic [`TLB_VPN_W-1:0]                              fill_vpn,
  input  logic [`TLB_PPN_W-1:0]                              fill_ppn,
  input  logic                                               clear,
  output logic [`TLB_ENTRIES-1:0]                            ent_valid,
  output logic [`TLB_ENTRIES*(`TLB_PID_W+`TLB_VPN_W)-1:0]    ent_tag,
  output logic [`TLB_ENTRIES*`TLB_PPN_W-1:0]                 ent_ppn
);

  localparam int tag_w = `TLB_PID_W + `TLB_VPN_W;
  localparam int ptr_w = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0] valid_q;
  logic [tag_w-1:0]        tag_q [`TLB_ENTRIES];
  logic [`TLB_PPN_W-1:0]   ppn_q [`TLB_ENTRIES];
  logic [ptr_w-1:0]        victim;  // next slot to replace
  logic                    do_fill;

  assign do_fill = fill_valid && !clear;  // clear wins

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      victim  <= '0;
    end else if (clear) begin
      valid_q <= '0;
    end else if (do_fill) begin
      valid_q[victim] <= 1'b1;
      victim          <= victim + ptr_w'(1);
    end
  end

  // tag and frame storage
  always_ff @(posedge clk) begin
    if (do_fill) begin
      tag_q[victim] <= {fill_pid, fill_vpn};
      ppn_q[victim] <= fill_ppn;
    end
  end

  assign ent_valid = valid_q;

  for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_flat
    assign ent_tag[i*tag_w +: tag_w]           = tag_q[i];
    assign ent_ppn[i*`TLB_PPN_W +: `TLB_PPN_W] = ppn_q[i];
  end

  // maintenance is serialized by the pipeline
  a_fill_clear: assert property (@(posedge clk) disable iff (rst)
    !(fill_valid && clear));

endmodule

/* verilog/tlb_lookup.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_lookup (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               req_valid,
  input  logic [31:0]                                        vaddr,
  input  logic [`TLB_PID_W-1:0]                              pid,
  input  logic                                               kmode,
  input  logic [7:0]                                         exc_in,
  input  logic [`TLB_ENTRIES-1:0]                            ent_valid,
  input  logic [`TLB_ENTRIES*(`TLB_PID_W+`TLB_VPN_W)-1:0]    ent_tag,
  input  logic [`TLB_ENTRIES*`TLB_PPN_W-1:0]                 ent_ppn,
  output logic                                               res_valid,
  output logic [`TLB_PA_W-1:0]                               res_paddr,
  output logic [7:0]                                         res_exc
);

  localparam int tag_w = `TLB_PID_W + `TLB_VPN_W;

  logic [tag_w-1:0]        key;
  logic [`TLB_ENTRIES-1:0] match;
  logic                    hit;
  logic [`TLB_PPN_W-1:0]   hit_ppn;
  logic                    low;
  logic [`TLB_PA_W-1:0]    paddr_d;
  tlb_pkg::exc_e           exc_d;
  tlb_pkg::exc_e           exc_q;

  assign key = {pid, vaddr[31:`TLB_OFF_W]};
  assign low = kmode && (vaddr < `TLB_LOW_LIMIT);  // kernel low region

  // scan downward so the lowest matching index is kept
  always_comb begin
    hit     = 1'b0;
    hit_ppn = '0;
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      match[i] = ent_valid[i] && (ent_tag[i*tag_w +: tag_w] == key);
      if (match[i]) begin
        hit     = 1'b1;
        hit_ppn = ent_ppn[i*`TLB_PPN_W +: `TLB_PPN_W];
      end
    end
  end

  always_comb begin
    if (exc_in != 8'h00) begin  // earlier stage fault
      paddr_d = '0;
      exc_d   = tlb_pkg::exc_e'(exc_in);
    end else if (low) begin
      paddr_d = vaddr[`TLB_PA_W-1:0];
      exc_d   = tlb_pkg::exc_none;
    end else if (hit) begin
      paddr_d = {hit_ppn, vaddr[`TLB_OFF_W-1:0]};
      exc_d   = tlb_pkg::exc_none;
    end else begin
      paddr_d = '0;
      exc_d   = kmode ? tlb_pkg::exc_kmiss : tlb_pkg::exc_umiss;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) res_valid <= 1'b0;
    else     res_valid <= req_valid;
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      res_paddr <= paddr_d;
      exc_q     <= exc_d;
    end
  end

  assign res_exc = exc_q;

  // fills never create duplicate keys
  a_one_match: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> $onehot0(match));

endmodule

/* verilog/tlb_macros.svh */
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// TLB geometry
`define TLB_ENTRIES 8

// virtual tag fields
`define TLB_PID_W 12
`define TLB_VPN_W 20

// physical address is frame plus page offset
`define TLB_PPN_W 6
`define TLB_OFF_W 12
`define TLB_PA_W 18

`define TLB_LOW_LIMIT 32'h0003_0000  // kernel bypass bound

// flow control
`define TLB_REQ_CREDITS 2
`define TLB_RESP_CREDITS 4

`endif

/* verilog/tlb_pkg.sv */
package tlb_pkg;

  // codes reported by a lookup
  typedef enum logic [7:0] {
    exc_none  = 8'h00,
    exc_umiss = 8'h82,  // user mode miss
    exc_kmiss = 8'h83   // kernel mode miss
  } exc_e;

  // response source
  typedef enum logic {
    port_inst = 1'b0,
    port_data = 1'b1
  } port_e;

endpackage

/* verilog/tlb_resp_merge.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_resp_merge (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_res_valid,
  input  logic [`TLB_PA_W-1:0]  inst_res_paddr,
  input  logic [7:0]            inst_res_exc,
  input  logic                  data_res_valid,
  input  logic [`TLB_PA_W-1:0]  data_res_paddr,
  input  logic [7:0]            data_res_exc,
  input  logic                  resp_credit,
  output logic                  inst_credit,
  output logic                  data_credit,
  output logic                  resp_valid,
  output tlb_pkg::port_e        resp_port,
  output logic [`TLB_PA_W-1:0]  resp_paddr,
  output logic [7:0]            resp_exc
);

  localparam int depth = `TLB_REQ_CREDITS;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);
  localparam int rc_w  = $clog2(`TLB_RESP_CREDITS + 1);

  logic [1:0]           in_valid;
  logic [`TLB_PA_W-1:0] in_paddr [2];
  tlb_pkg::exc_e        in_exc [2];

  logic [`TLB_PA_W-1:0] q_paddr [2][depth];
  tlb_pkg::exc_e        q_exc [2][depth];
  logic [ptr_w-1:0]     wr_ptr [2];
  logic [ptr_w-1:0]     rd_ptr [2];
  logic [cnt_w-1:0]     q_cnt [2];

  logic [1:0]           avail;
  logic [`TLB_PA_W-1:0] head_paddr [2];
  tlb_pkg::exc_e        head_exc [2];
  logic [1:0]           push;
  logic [1:0]           pop;
  logic [1:0]           grant;
  logic [1:0]           credit_q;
  logic [rc_w-1:0]      rc_cnt;  // downstream slots left
  logic                 prio;    // favored port on a tie
  logic                 send;
  tlb_pkg::port_e       sel;

  assign in_valid[tlb_pkg::port_inst] = inst_res_valid;
  assign in_valid[tlb_pkg::port_data] = data_res_valid;
  assign in_paddr[tlb_pkg::port_inst] = inst_res_paddr;
  assign in_paddr[tlb_pkg::port_data] = data_res_paddr;
  assign in_exc[tlb_pkg::port_inst]   = tlb_pkg::exc_e'(inst_res_exc);
  assign in_exc[tlb_pkg::port_data]   = tlb_pkg::exc_e'(data_res_exc);

  always_comb begin
    // an empty queue forwards the incoming result directly
    for (int p = 0; p < 2; p++) begin
      avail[p]      = (q_cnt[p] != '0) || in_valid[p];
      head_paddr[p] = (q_cnt[p] != '0) ? q_paddr[p][rd_ptr[p]] : in_paddr[p];
      head_exc[p]   = (q_cnt[p] != '0) ? q_exc[p][rd_ptr[p]] : in_exc[p];
    end

    if (avail == 2'b11)  sel = tlb_pkg::port_e'(prio);
    else if (avail[1])   sel = tlb_pkg::port_data;
    else                 sel = tlb_pkg::port_inst;

    send       = (avail != 2'b00) && (rc_cnt != '0);
    grant      = 2'b00;
    grant[sel] = send;

    for (int p = 0; p < 2; p++) begin
      pop[p]  = grant[p] && (q_cnt[p] != '0);
      push[p] = in_valid[p] && !(grant[p] && (q_cnt[p] == '0));
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (push[p]) begin
        q_paddr[p][wr_ptr[p]] <= in_paddr[p];
        q_exc[p][wr_ptr[p]]   <= in_exc[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < 2; p++) begin
        wr_ptr[p] <= '0;
        rd_ptr[p] <= '0;
        q_cnt[p]  <= '0;
      end
      prio       <= 1'b0;
      rc_cnt     <= rc_w'(`TLB_RESP_CREDITS);
      resp_valid <= 1'b0;
      credit_q   <= 2'b00;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (push[p]) wr_ptr[p] <= wr_ptr[p] + ptr_w'(1);
        if (pop[p])  rd_ptr[p] <= rd_ptr[p] + ptr_w'(1);
        q_cnt[p] <= q_cnt[p] + cnt_w'(push[p]) - cnt_w'(pop[p]);
      end
      if (send) prio <= (sel == tlb_pkg::port_inst);  // other port next
      rc_cnt     <= rc_cnt - rc_w'(send) + rc_w'(resp_credit);
      resp_valid <= send;
      credit_q   <= grant;  // credit back on the dequeue edge
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      resp_port  <= sel;
      resp_paddr <= head_paddr[sel];
      resp_exc   <= head_exc[sel];
    end
  end

  assign inst_credit = credit_q[tlb_pkg::port_inst];
  assign data_credit = credit_q[tlb_pkg::port_data];

  // senders stay within their request credits
  for (genvar p = 0; p < 2; p++) begin : g_chk
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      push[p] |-> (q_cnt[p] < depth));
  end

  // downstream never returns more than it was given
  a_rc_bound: assert property (@(posedge clk) disable iff (rst)
    rc_cnt <= `TLB_RESP_CREDITS);

endmodule

/* verilog/tlb_top.sv */
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid,
  input  logic [31:0]           inst_vaddr,
  input  logic [`TLB_PID_W-1:0] inst_pid,
  input  logic                  inst_kmode,
  input  logic                  data_valid,
  input  logic [31:0]           data_vaddr,
  input  logic [`TLB_PID_W-1:0] data_pid,
  input  logic                  data_kmode,
  input  logic [7:0]            data_exc_in,
  input  logic                  fill_valid,
  input  logic [`TLB_PID_W-1:0] fill_pid,
  input  logic [`TLB_VPN_W-1:0] fill_vpn,
  input  logic [`TLB_PPN_W-1:0] fill_ppn,
  input  logic                  clear,
  output logic                  inst_credit,
  output logic                  data_credit,
  output logic                  resp_valid,
  output tlb_pkg::port_e        resp_port,
  output logic [`TLB_PA_W-1:0]  resp_paddr,
  output logic [7:0]            resp_exc,
  input  logic                  resp_credit
);

  logic [`TLB_ENTRIES-1:0]                         ent_valid;
  logic [`TLB_ENTRIES*(`TLB_PID_W+`TLB_VPN_W)-1:0] ent_tag;
  logic [`TLB_ENTRIES*`TLB_PPN_W-1:0]              ent_ppn;

  logic                 inst_res_valid;
  logic [`TLB_PA_W-1:0] inst_res_paddr;
  logic [7:0]           inst_res_exc;
  logic                 data_res_valid;
  logic [`TLB_PA_W-1:0] data_res_paddr;
  logic [7:0]           data_res_exc;

  tlb_entry_store u_store (
    .clk        (clk),
    .rst        (rst),
    .fill_valid (fill_valid),
    .fill_pid   (fill_pid),
    .fill_vpn   (fill_vpn),
    .fill_ppn   (fill_ppn),
    .clear      (clear),
    .ent_valid  (ent_valid),
    .ent_tag    (ent_tag),
    .ent_ppn    (ent_ppn)
  );

  tlb_lookup u_inst_lookup (
    .clk       (clk),
    .rst       (rst),
    .req_valid (inst_valid),
    .vaddr     (inst_vaddr),
    .pid       (inst_pid),
    .kmode     (inst_kmode),
    .exc_in    (8'h00),  // no upstream faults on fetch
    .ent_valid (ent_valid),
    .ent_tag   (ent_tag),
    .ent_ppn   (ent_ppn),
    .res_valid (inst_res_valid),
    .res_paddr (inst_res_paddr),
    .res_exc   (inst_res_exc)
  );

  tlb_lookup u_data_lookup (
    .clk       (clk),
    .rst       (rst),
    .req_valid (data_valid),
    .vaddr     (data_vaddr),
    .pid       (data_pid),
    .kmode     (data_kmode),
    .exc_in    (data_exc_in),
    .ent_valid (ent_valid),
    .ent_tag   (ent_tag),
    .ent_ppn   (ent_ppn),
    .res_valid (data_res_valid),
    .res_paddr (data_res_paddr),
    .res_exc   (data_res_exc)
  );

  tlb_resp_merge u_merge (
    .clk            (clk),
    .rst            (rst),
    .inst_res_valid (inst_res_valid),
    .inst_res_paddr (inst_res_paddr),
    .inst_res_exc   (inst_res_exc),
    .data_res_valid (data_res_valid),
    .data_res_paddr (data_res_paddr),
    .data_res_exc   (data_res_exc),
    .resp_credit    (resp_credit),
    .inst_credit    (inst_credit),
    .data_credit    (data_credit),
    .resp_valid     (resp_valid),
    .resp_port      (resp_port),
    .resp_paddr     (resp_paddr),
    .resp_exc       (resp_exc)
  );

endmodule
